// ==== include/ex_defs.svh ====
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// datapath widths
`define EX_DATA_W   32
`define EX_REG_AW   5
`define EX_SHAMT_W  5
`define EX_SEL_W    3
`define EX_OP_W     8
// wide enough to hold a count of 0 to 32
`define EX_CNT_W    6

////////////////////
// alusel classes
////////////////////
`define EX_SEL_NOP    3'b000
`define EX_SEL_LOGIC  3'b001
`define EX_SEL_SHIFT  3'b010
`define EX_SEL_MOVE   3'b011
`define EX_SEL_ARITH  3'b100
`define EX_SEL_LINK   3'b101

////////////////////
// aluop codes, only unique within one class
////////////////////
`define EX_OP_AND     8'b00100100
`define EX_OP_OR      8'b00100101
`define EX_OP_XOR     8'b00100110
`define EX_OP_NOR     8'b00100111
`define EX_OP_ANDI    8'b00001100
`define EX_OP_ORI     8'b00001101
`define EX_OP_XORI    8'b00001110
`define EX_OP_LUI     8'b00001111

`define EX_OP_SLL     8'b00000000
`define EX_OP_SLLV    8'b00000100
`define EX_OP_SRL     8'b00000010
`define EX_OP_SRLV    8'b00000110
`define EX_OP_SRA     8'b00000011
`define EX_OP_SRAV    8'b00000111

`define EX_OP_MOVZ    8'b00001010
`define EX_OP_MOVN    8'b00001011
`define EX_OP_MFHI    8'b00010000
`define EX_OP_MTHI    8'b00010001
`define EX_OP_MFLO    8'b00010010
`define EX_OP_MTLO    8'b00010011

`define EX_OP_ADD     8'b00100000
`define EX_OP_ADDU    8'b00100001
`define EX_OP_ADDI    8'b00001000
`define EX_OP_ADDIU   8'b00001001
`define EX_OP_SUB     8'b00100010
`define EX_OP_SUBU    8'b00100011
`define EX_OP_SLT     8'b00101010
`define EX_OP_SLTU    8'b00101011
`define EX_OP_SLTI    8'b00001010
`define EX_OP_SLTIU   8'b00001011
`define EX_OP_MUL     8'b00000010
`define EX_OP_MULT    8'b00011000
`define EX_OP_MULTU   8'b00011001
`define EX_OP_CLZ     8'b11100000
`define EX_OP_CLO     8'b11100001

`endif

// ==== hw/ex_pkg.sv ====
`default_nettype none

`include "ex_defs.svh"

package ex_pkg;

	// one operation as handed over by decode
	// reg1 doubles as shift amount, reg2 as sign-extended immediate
	typedef struct packed {
		logic [`EX_SEL_W-1:0]   alusel;
		logic [`EX_OP_W-1:0]    aluop;
		logic [`EX_DATA_W-1:0]  reg1;
		logic [`EX_DATA_W-1:0]  reg2;
		logic                   we;
		logic [`EX_REG_AW-1:0]  waddr;
		logic [`EX_DATA_W-1:0]  link_addr;
	} ex_op_t;

	// register file write-back
	typedef struct packed {
		logic                   we;
		logic [`EX_REG_AW-1:0]  waddr;
		logic [`EX_DATA_W-1:0]  wdata;
	} ex_wb_t;

	// pending write to hi/lo
	typedef struct packed {
		logic                   whilo;
		logic [`EX_DATA_W-1:0]  hi;
		logic [`EX_DATA_W-1:0]  lo;
	} ex_hilo_req_t;

	// current hi/lo value
	typedef struct packed {
		logic [`EX_DATA_W-1:0]  hi;
		logic [`EX_DATA_W-1:0]  lo;
	} ex_hilo_t;

endpackage

`default_nettype wire

// ==== hw/ex_arith_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ex_defs.svh"

module ex_arith_unit (
	input  wire ex_pkg::ex_op_t         op_i,
	output logic [`EX_DATA_W-1:0]       result_o,
	output logic [2*`EX_DATA_W-1:0]     product_o,
	output logic                        overflow_o
);

	logic                       is_arith;
	logic [`EX_DATA_W-1:0]      sum;
	logic [`EX_DATA_W:0]        diff_ext;
	logic [`EX_DATA_W-1:0]      diff;
	logic                       add_ovf;
	logic                       sub_ovf;
	logic                       lt_signed;
	logic                       lt_unsigned;
	logic                       mul_signed;
	logic [2*`EX_DATA_W-1:0]    mul_a;
	logic [2*`EX_DATA_W-1:0]    mul_b;
	logic [`EX_CNT_W-1:0]       lead_cnt;

	// zeros from the msb down to the first one
	function automatic logic [`EX_CNT_W-1:0] count_lead_zeros(input logic [`EX_DATA_W-1:0] v);
		logic [`EX_CNT_W-1:0] n;
		logic                 found;
		n = '0;
		found = 1'b0;
		for (int i = `EX_DATA_W - 1; i >= 0; i--) begin
			if (v[i])
				found = 1'b1;
			else if (!found)
				n = n + 1'b1;
		end
		return n;
	endfunction

	assign is_arith = (op_i.alusel == `EX_SEL_ARITH);

	////////////////////
	// add / subtract
	////////////////////
	assign sum      = op_i.reg1 + op_i.reg2;
	// extra bit gives the unsigned borrow
	assign diff_ext = {1'b0, op_i.reg1} - {1'b0, op_i.reg2};
	assign diff     = diff_ext[`EX_DATA_W-1:0];

	// same-sign operands, result sign flipped
	assign add_ovf = (op_i.reg1[`EX_DATA_W-1] == op_i.reg2[`EX_DATA_W-1]) &&
		(sum[`EX_DATA_W-1] != op_i.reg1[`EX_DATA_W-1]);
	assign sub_ovf = (op_i.reg1[`EX_DATA_W-1] != op_i.reg2[`EX_DATA_W-1]) &&
		(diff[`EX_DATA_W-1] != op_i.reg1[`EX_DATA_W-1]);

	assign overflow_o = is_arith && (
		((op_i.aluop == `EX_OP_ADD || op_i.aluop == `EX_OP_ADDI) && add_ovf) ||
		((op_i.aluop == `EX_OP_SUB) && sub_ovf));

	// compare reuses the subtractor
	assign lt_signed   = diff[`EX_DATA_W-1] ^ sub_ovf;
	assign lt_unsigned = diff_ext[`EX_DATA_W];

	////////////////////
	// multiply
	////////////////////
	assign mul_signed = (op_i.aluop != `EX_OP_MULTU);
	assign mul_a = {{`EX_DATA_W{mul_signed & op_i.reg1[`EX_DATA_W-1]}}, op_i.reg1};
	assign mul_b = {{`EX_DATA_W{mul_signed & op_i.reg2[`EX_DATA_W-1]}}, op_i.reg2};
	// low 64 bits are right for both signed and unsigned
	assign product_o = mul_a * mul_b;

	// clo counts the zeros of the inverted word
	always_comb begin
		if (op_i.aluop == `EX_OP_CLO)
			lead_cnt = count_lead_zeros(~op_i.reg1);
		else
			lead_cnt = count_lead_zeros(op_i.reg1);
		count_range_a: assert (lead_cnt <= `EX_CNT_W'(`EX_DATA_W))
			else $error("leading count %0d above word width", lead_cnt);
	end

	////////////////////
	// result select
	////////////////////
	always_comb begin
		result_o = '0;
		if (is_arith) begin
			case (op_i.aluop)
				`EX_OP_ADD, `EX_OP_ADDU, `EX_OP_ADDI, `EX_OP_ADDIU:
					result_o = sum;
				`EX_OP_SUB, `EX_OP_SUBU:
					result_o = diff;
				`EX_OP_SLT, `EX_OP_SLTI:
					result_o = {{(`EX_DATA_W-1){1'b0}}, lt_signed};
				`EX_OP_SLTU, `EX_OP_SLTIU:
					result_o = {{(`EX_DATA_W-1){1'b0}}, lt_unsigned};
				`EX_OP_CLZ, `EX_OP_CLO:
					result_o = {{(`EX_DATA_W-`EX_CNT_W){1'b0}}, lead_cnt};
				`EX_OP_MUL:
					result_o = product_o[`EX_DATA_W-1:0];
				default:
					result_o = '0;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hw/ex_alu.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ex_defs.svh"

module ex_alu (
	input  wire                         clk,
	input  wire                         reset_n,
	input  wire ex_pkg::ex_op_t         op_i,
	input  wire ex_pkg::ex_hilo_t       hilo_fwd_i,
	output ex_pkg::ex_wb_t              wb_o,
	output ex_pkg::ex_hilo_req_t        hilo_req_o
);

	import ex_pkg::*;

	logic [`EX_SHAMT_W-1:0]     shamt;
	logic [`EX_DATA_W-1:0]      logic_res;
	logic [`EX_DATA_W-1:0]      shift_res;
	logic [`EX_DATA_W-1:0]      move_res;
	logic [`EX_DATA_W-1:0]      arith_res;
	logic [2*`EX_DATA_W-1:0]    product;
	logic                       overflow;
	logic                       is_mult;
	logic                       no_write;
	ex_wb_t                     wb_d;
	ex_hilo_req_t               hilo_d;

	ex_arith_unit u_arith (
		.op_i       (op_i),
		.result_o   (arith_res),
		.product_o  (product),
		.overflow_o (overflow)
	);

	assign shamt   = op_i.reg1[`EX_SHAMT_W-1:0];
	assign is_mult = (op_i.alusel == `EX_SEL_ARITH) &&
		(op_i.aluop == `EX_OP_MULT || op_i.aluop == `EX_OP_MULTU);

	////////////////////
	// logic, shift, move
	////////////////////
	always_comb begin
		case (op_i.aluop)
			`EX_OP_AND, `EX_OP_ANDI: logic_res = op_i.reg1 & op_i.reg2;
			`EX_OP_OR, `EX_OP_ORI:   logic_res = op_i.reg1 | op_i.reg2;
			`EX_OP_XOR, `EX_OP_XORI: logic_res = op_i.reg1 ^ op_i.reg2;
			`EX_OP_NOR:              logic_res = ~(op_i.reg1 | op_i.reg2);
			// immediate goes to the upper half
			`EX_OP_LUI:
				logic_res = {op_i.reg2[`EX_DATA_W/2-1:0], {(`EX_DATA_W/2){1'b0}}};
			default:                 logic_res = '0;
		endcase
	end

	always_comb begin
		case (op_i.aluop)
			`EX_OP_SLL, `EX_OP_SLLV: shift_res = op_i.reg2 << shamt;
			`EX_OP_SRL, `EX_OP_SRLV: shift_res = op_i.reg2 >> shamt;
			`EX_OP_SRA, `EX_OP_SRAV: shift_res = $unsigned($signed(op_i.reg2) >>> shamt);
			default:                 shift_res = '0;
		endcase
	end

	// hi/lo reads take the forwarded value
	always_comb begin
		case (op_i.aluop)
			`EX_OP_MOVZ, `EX_OP_MOVN: move_res = op_i.reg1;
			`EX_OP_MFHI:              move_res = hilo_fwd_i.hi;
			`EX_OP_MFLO:              move_res = hilo_fwd_i.lo;
			default:                  move_res = '0;
		endcase
	end

	////////////////////
	// write-back select
	////////////////////
	always_comb begin
		no_write = 1'b0;
		if (op_i.alusel == `EX_SEL_MOVE) begin
			case (op_i.aluop)
				`EX_OP_MOVZ:              no_write = (op_i.reg2 != '0);
				`EX_OP_MOVN:              no_write = (op_i.reg2 == '0);
				`EX_OP_MTHI, `EX_OP_MTLO: no_write = 1'b1;
				default:                  no_write = 1'b0;
			endcase
		end else if (op_i.alusel == `EX_SEL_ARITH) begin
			no_write = overflow || is_mult;
		end
	end

	always_comb begin
		wb_d.we    = op_i.we && !no_write;
		wb_d.waddr = op_i.waddr;
		case (op_i.alusel)
			`EX_SEL_LOGIC: wb_d.wdata = logic_res;
			`EX_SEL_SHIFT: wb_d.wdata = shift_res;
			`EX_SEL_MOVE:  wb_d.wdata = move_res;
			`EX_SEL_ARITH: wb_d.wdata = arith_res;
			`EX_SEL_LINK:  wb_d.wdata = op_i.link_addr;
			default:       wb_d.wdata = '0;
		endcase
	end

	// mthi/mtlo keep the other half as currently seen
	always_comb begin
		hilo_d = '0;
		if (op_i.alusel == `EX_SEL_MOVE && op_i.aluop == `EX_OP_MTHI) begin
			hilo_d.whilo = 1'b1;
			hilo_d.hi    = op_i.reg1;
			hilo_d.lo    = hilo_fwd_i.lo;
		end else if (op_i.alusel == `EX_SEL_MOVE && op_i.aluop == `EX_OP_MTLO) begin
			hilo_d.whilo = 1'b1;
			hilo_d.hi    = hilo_fwd_i.hi;
			hilo_d.lo    = op_i.reg1;
		end else if (is_mult) begin
			hilo_d.whilo = 1'b1;
			hilo_d.hi    = product[2*`EX_DATA_W-1:`EX_DATA_W];
			hilo_d.lo    = product[`EX_DATA_W-1:0];
		end
	end

	// stage output register
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			wb_o       <= '0;
			hilo_req_o <= '0;
		end else begin
			wb_o       <= wb_d;
			hilo_req_o <= hilo_d;
		end
	end

	// a hi/lo write only comes from moves or multiplies
	whilo_src_a: assert property (@(posedge clk) disable iff (!reset_n)
		$rose(hilo_req_o.whilo) |->
			($past(op_i.alusel) == `EX_SEL_MOVE || $past(op_i.alusel) == `EX_SEL_ARITH))
		else $error("hilo write without a move or arith op");

endmodule

`default_nettype wire

// ==== hw/ex_hilo_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ex_defs.svh"

module ex_hilo_unit (
	input  wire                         clk,
	input  wire                         reset_n,
	input  wire ex_pkg::ex_hilo_req_t   hilo_req_i,
	output ex_pkg::ex_hilo_t            hilo_fwd_o
);

	import ex_pkg::*;

	ex_hilo_t hilo_q;

	////////////////////
	// architectural hi/lo
	////////////////////
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			hilo_q <= '0;
		end else if (hilo_req_i.whilo) begin
			hilo_q.hi <= hilo_req_i.hi;
			hilo_q.lo <= hilo_req_i.lo;
		end
	end

	////////////////////
	// forwarding
	////////////////////
	// a request still sitting in the stage register wins
	always_comb begin
		if (hilo_req_i.whilo) begin
			hilo_fwd_o.hi = hilo_req_i.hi;
			hilo_fwd_o.lo = hilo_req_i.lo;
		end else begin
			hilo_fwd_o = hilo_q;
		end
	end

	// hi/lo holds when no write is requested
	hilo_hold_a: assert property (@(posedge clk) disable iff (!reset_n)
		!hilo_req_i.whilo |=> $stable(hilo_q))
		else $error("hi/lo changed without a write request");

endmodule

`default_nettype wire

// ==== hw/ex_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ex_top (
	input  wire                         clk,
	input  wire                         reset_n,
	input  wire ex_pkg::ex_op_t         op_i,
	output wire ex_pkg::ex_wb_t         wb_o,
	output wire ex_pkg::ex_hilo_req_t   hilo_o
);

	import ex_pkg::*;

	// hi/lo as seen by the alu, forwarding already applied
	ex_hilo_t hilo_fwd;

	////////////////////
	// execute datapath
	////////////////////
	ex_alu u_alu (
		.clk        (clk),
		.reset_n    (reset_n),
		.op_i       (op_i),
		.hilo_fwd_i (hilo_fwd),
		.wb_o       (wb_o),
		.hilo_req_o (hilo_o)
	);

	////////////////////
	// hi/lo storage
	////////////////////
	// fed from the registered request, so the write lands one edge later
	ex_hilo_unit u_hilo (
		.clk        (clk),
		.reset_n    (reset_n),
		.hilo_req_i (hilo_o),
		.hilo_fwd_o (hilo_fwd)
	);

endmodule

`default_nettype wire

// ==== tests/ex_top_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ex_defs.svh"

module ex_top_tb;

	import ex_pkg::*;

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 5;
	localparam int MAX_ROWS     = 128;
	localparam int MAX_TESTS    = 16;

	logic           clk;
	logic           reset_n;
	ex_op_t         op;
	ex_wb_t         wb;
	ex_hilo_req_t   hilo;

	// one row of stimulus and expected response per cycle
	ex_op_t         op_tab [0:MAX_ROWS-1];
	ex_wb_t         wb_tab [0:MAX_ROWS-1];
	ex_hilo_req_t   hilo_tab [0:MAX_ROWS-1];
	int             row_test [0:MAX_ROWS-1];
	string          test_name [0:MAX_TESTS-1];
	int             test_errs [0:MAX_TESTS-1];
	int             n_rows = 0;
	int             n_tests = 0;
	int             n_checks = 0;
	int             n_errors = 0;
	logic           table_ready = 1'b0;
	logic [31:0]    rng = 32'hb042;

	ex_top dut (
		.clk     (clk),
		.reset_n (reset_n),
		.op_i    (op),
		.wb_o    (wb),
		.hilo_o  (hilo)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	////////////////////
	// helpers
	////////////////////
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [`EX_DATA_W-1:0] link_of(input int idx);
		return 32'hbfc0_0000 + 32'(idx * 4);
	endfunction

	// no-op rows carry we low
	function automatic ex_op_t make_op(input logic [`EX_SEL_W-1:0] sel,
		input logic [`EX_OP_W-1:0] aluop, input logic [31:0] r1, input logic [31:0] r2);
		ex_op_t o;
		o.alusel    = sel;
		o.aluop     = aluop;
		o.reg1      = r1;
		o.reg2      = r2;
		o.we        = (sel != `EX_SEL_NOP);
		o.waddr     = n_rows[`EX_REG_AW-1:0];
		o.link_addr = link_of(n_rows);
		return o;
	endfunction

	task automatic begin_test(input string name);
		test_name[n_tests] = name;
		test_errs[n_tests] = 0;
		n_tests++;
	endtask

	task automatic add_row(input ex_op_t o, input ex_wb_t w, input ex_hilo_req_t h);
		op_tab[n_rows]   = o;
		wb_tab[n_rows]   = w;
		hilo_tab[n_rows] = h;
		row_test[n_rows] = n_tests - 1;
		n_rows++;
	endtask

	task automatic add_wb_row(input logic [`EX_SEL_W-1:0] sel, input logic [`EX_OP_W-1:0] aluop,
		input logic [31:0] r1, input logic [31:0] r2, input logic we, input logic [31:0] wdata);
		ex_wb_t w;
		w.we    = we;
		w.waddr = n_rows[`EX_REG_AW-1:0];
		w.wdata = wdata;
		add_row(make_op(sel, aluop, r1, r2), w, '0);
	endtask

	// rows that write hi/lo and never the register file
	task automatic add_hilo_row(input logic [`EX_SEL_W-1:0] sel, input logic [`EX_OP_W-1:0] aluop,
		input logic [31:0] r1, input logic [31:0] r2, input logic [31:0] hi, input logic [31:0] lo);
		ex_wb_t       w;
		ex_hilo_req_t h;
		w.we    = 1'b0;
		w.waddr = n_rows[`EX_REG_AW-1:0];
		w.wdata = '0;
		h.whilo = 1'b1;
		h.hi    = hi;
		h.lo    = lo;
		add_row(make_op(sel, aluop, r1, r2), w, h);
	endtask

	////////////////////
	// reference model
	////////////////////
	task automatic model_expect(input ex_op_t o, output ex_wb_t w, output ex_hilo_req_t h);
		logic [32:0] s;
		longint      p;
		w.we    = o.we;
		w.waddr = o.waddr;
		w.wdata = '0;
		h       = '0;
		case ({o.alusel, o.aluop})
			{`EX_SEL_LOGIC, `EX_OP_XOR}: w.wdata = o.reg1 ^ o.reg2;
			{`EX_SEL_ARITH, `EX_OP_ADD}: begin
				// top two bits of the sign-extended sum differ on overflow
				s = {o.reg1[31], o.reg1} + {o.reg2[31], o.reg2};
				w.wdata = s[31:0];
				if (s[32] != s[31])
					w.we = 1'b0;
			end
			{`EX_SEL_ARITH, `EX_OP_SLTU}: w.wdata = 32'(o.reg1 < o.reg2);
			{`EX_SEL_ARITH, `EX_OP_MULT}: begin
				p = longint'($signed(o.reg1)) * longint'($signed(o.reg2));
				w.we    = 1'b0;
				h.whilo = 1'b1;
				h.hi    = p[63:32];
				h.lo    = p[31:0];
			end
			default: w.we = 1'b0;
		endcase
	endtask

	task automatic add_random_row(input logic [`EX_SEL_W-1:0] sel, input logic [`EX_OP_W-1:0] aluop);
		logic [31:0]  a;
		logic [31:0]  b;
		ex_op_t       o;
		ex_wb_t       w;
		ex_hilo_req_t h;
		rng = xorshift32(rng);
		a = rng;
		rng = xorshift32(rng);
		b = rng;
		o = make_op(sel, aluop, a, b);
		model_expect(o, w, h);
		add_row(o, w, h);
	endtask

	task automatic build_table();
		begin_test("reset");
		add_wb_row(`EX_SEL_MOVE, `EX_OP_MFHI, 0, 0, 1'b1, 32'h00000000);
		add_wb_row(`EX_SEL_MOVE, `EX_OP_MFLO, 0, 0, 1'b1, 32'h00000000);

		begin_test("logic");
		add_wb_row(`EX_SEL_LOGIC, `EX_OP_AND, 32'hf0f01234, 32'h0ff0ff00, 1'b1, 32'h00f01200);
		add_wb_row(`EX_SEL_LOGIC, `EX_OP_OR, 32'hf0f01234, 32'h0ff0ff00, 1'b1, 32'hfff0ff34);
		add_wb_row(`EX_SEL_LOGIC, `EX_OP_XOR, 32'hf0f01234, 32'h0ff0ff00, 1'b1, 32'hff00ed34);
		add_wb_row(`EX_SEL_LOGIC, `EX_OP_NOR, 32'hf0f01234, 32'h0ff0ff00, 1'b1, 32'h000f00cb);
		add_wb_row(`EX_SEL_LOGIC, `EX_OP_ANDI, 32'h12345678, 32'h0000ff0f, 1'b1, 32'h00005608);
		add_wb_row(`EX_SEL_LOGIC, `EX_OP_ORI, 32'h12345678, 32'h000000f0, 1'b1, 32'h123456f8);
		add_wb_row(`EX_SEL_LOGIC, `EX_OP_XORI, 32'h12345678, 32'h0000ffff, 1'b1, 32'h1234a987);
		add_wb_row(`EX_SEL_LOGIC, `EX_OP_LUI, 0, 32'h0000abcd, 1'b1, 32'habcd0000);
		add_wb_row(`EX_SEL_LOGIC, `EX_OP_LUI, 0, 32'hffff8001, 1'b1, 32'h80010000);

		// reg1 holds the shift amount
		begin_test("shift");
		add_wb_row(`EX_SEL_SHIFT, `EX_OP_SLL, 4, 32'h87654321, 1'b1, 32'h76543210);
		add_wb_row(`EX_SEL_SHIFT, `EX_OP_SLL, 0, 32'h87654321, 1'b1, 32'h87654321);
		add_wb_row(`EX_SEL_SHIFT, `EX_OP_SLLV, 31, 32'h00000003, 1'b1, 32'h80000000);
		add_wb_row(`EX_SEL_SHIFT, `EX_OP_SRL, 4, 32'h87654321, 1'b1, 32'h08765432);
		add_wb_row(`EX_SEL_SHIFT, `EX_OP_SRL, 8, 32'h76543210, 1'b1, 32'h00765432);
		add_wb_row(`EX_SEL_SHIFT, `EX_OP_SRLV, 31, 32'h80000000, 1'b1, 32'h00000001);
		add_wb_row(`EX_SEL_SHIFT, `EX_OP_SRA, 4, 32'h87654321, 1'b1, 32'hf8765432);
		add_wb_row(`EX_SEL_SHIFT, `EX_OP_SRA, 4, 32'h76543210, 1'b1, 32'h07654321);
		add_wb_row(`EX_SEL_SHIFT, `EX_OP_SRAV, 31, 32'h80000000, 1'b1, 32'hffffffff);
		add_wb_row(`EX_SEL_SHIFT, `EX_OP_SRA, 0, 32'h87654321, 1'b1, 32'h87654321);

		begin_test("arith");
		add_wb_row(`EX_SEL_ARITH, `EX_OP_ADD, 32'h00001000, 32'h00000234, 1'b1, 32'h00001234);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_ADDU, 32'hffffffff, 32'h00000002, 1'b1, 32'h00000001);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_SUB, 32'h0000000a, 32'h00000003, 1'b1, 32'h00000007);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_SUBU, 32'h00000003, 32'h0000000a, 1'b1, 32'hfffffff9);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_ADDI, 32'h00000064, 32'hfffffffc, 1'b1, 32'h00000060);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_ADDIU, 32'h7fffffff, 32'hffffffff, 1'b1, 32'h7ffffffe);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_ADD, 32'h7fffffff, 32'h00000001, 1'b0, 32'h0);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_ADDU, 32'h7fffffff, 32'h00000001, 1'b1, 32'h80000000);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_SUB, 32'h80000000, 32'h00000001, 1'b0, 32'h0);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_SLT, 32'hffffffff, 32'h00000001, 1'b1, 32'h00000001);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_SLTU, 32'hffffffff, 32'h00000001, 1'b1, 32'h00000000);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_SLTI, 32'hfffffff0, 32'hfffffff8, 1'b1, 32'h00000001);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_SLTIU, 32'h00000005, 32'hffffffff, 1'b1, 32'h00000001);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_CLZ, 32'h00000000, 0, 1'b1, 32'h00000020);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_CLZ, 32'h00010000, 0, 1'b1, 32'h0000000f);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_CLO, 32'hffffffff, 0, 1'b1, 32'h00000020);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_CLO, 32'hf0000000, 0, 1'b1, 32'h00000004);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_MUL, 32'h00010003, 32'h00020005, 1'b1, 32'h000b000f);
		add_wb_row(`EX_SEL_ARITH, `EX_OP_MUL, 32'hfffffffd, 32'h00000005, 1'b1, 32'hfffffff1);

		begin_test("mult");
		add_hilo_row(`EX_SEL_ARITH, `EX_OP_MULT, 32'hfffffffd, 5, 32'hffffffff, 32'hfffffff1);
		add_hilo_row(`EX_SEL_ARITH, `EX_OP_MULTU, 32'hfffffffd, 5, 32'h00000004, 32'hfffffff1);

		// back-to-back rows read through forwarding and idle gaps read the register
		begin_test("hilo");
		add_hilo_row(`EX_SEL_MOVE, `EX_OP_MTHI, 32'h11112222, 0, 32'h11112222, 32'hfffffff1);
		add_wb_row(`EX_SEL_MOVE, `EX_OP_MFLO, 0, 0, 1'b1, 32'hfffffff1);
		add_wb_row(`EX_SEL_MOVE, `EX_OP_MFHI, 0, 0, 1'b1, 32'h11112222);
		add_hilo_row(`EX_SEL_MOVE, `EX_OP_MTHI, 32'h55556666, 0, 32'h55556666, 32'hfffffff1);
		add_wb_row(`EX_SEL_NOP, 8'h00, 0, 0, 1'b0, 32'h0);
		add_wb_row(`EX_SEL_NOP, 8'h00, 0, 0, 1'b0, 32'h0);
		add_wb_row(`EX_SEL_MOVE, `EX_OP_MFLO, 0, 0, 1'b1, 32'hfffffff1);
		add_wb_row(`EX_SEL_MOVE, `EX_OP_MFHI, 0, 0, 1'b1, 32'h55556666);
		add_hilo_row(`EX_SEL_MOVE, `EX_OP_MTLO, 32'h33334444, 0, 32'h55556666, 32'h33334444);
		add_wb_row(`EX_SEL_MOVE, `EX_OP_MFLO, 0, 0, 1'b1, 32'h33334444);
		add_hilo_row(`EX_SEL_MOVE, `EX_OP_MTHI, 32'h77778888, 0, 32'h77778888, 32'h33334444);
		add_wb_row(`EX_SEL_MOVE, `EX_OP_MFHI, 0, 0, 1'b1, 32'h77778888);

		begin_test("cmove");
		add_wb_row(`EX_SEL_MOVE, `EX_OP_MOVZ, 32'hdeadbeef, 0, 1'b1, 32'hdeadbeef);
		add_wb_row(`EX_SEL_MOVE, `EX_OP_MOVZ, 32'hdeadbeef, 1, 1'b0, 32'h0);
		add_wb_row(`EX_SEL_MOVE, `EX_OP_MOVN, 32'h0badf00d, 5, 1'b1, 32'h0badf00d);
		add_wb_row(`EX_SEL_MOVE, `EX_OP_MOVN, 32'h0badf00d, 0, 1'b0, 32'h0);
		add_wb_row(`EX_SEL_LINK, 8'h00, 0, 0, 1'b1, link_of(n_rows));

		begin_test("random");
		for (int k = 0; k < 4; k++) begin
			add_random_row(`EX_SEL_ARITH, `EX_OP_ADD);
			add_random_row(`EX_SEL_LOGIC, `EX_OP_XOR);
			add_random_row(`EX_SEL_ARITH, `EX_OP_SLTU);
			add_random_row(`EX_SEL_ARITH, `EX_OP_MULT);
		end
	endtask

	////////////////////
	// checking
	////////////////////
	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp, input int t);
		n_checks++;
		if (got !== exp) begin
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
			n_errors++;
			test_errs[t]++;
		end
	endtask

	// wdata and hi/lo only matter when their enable is expected high
	task automatic check_row(input int i);
		int t;
		t = row_test[i];
		check_value($sformatf("row %0d wb_o.we", i), 64'(wb.we), 64'(wb_tab[i].we), t);
		check_value($sformatf("row %0d wb_o.waddr", i), 64'(wb.waddr), 64'(wb_tab[i].waddr), t);
		if (wb_tab[i].we)
			check_value($sformatf("row %0d wb_o.wdata", i), 64'(wb.wdata),
				64'(wb_tab[i].wdata), t);
		check_value($sformatf("row %0d hilo_o.whilo", i), 64'(hilo.whilo),
			64'(hilo_tab[i].whilo), t);
		if (hilo_tab[i].whilo) begin
			check_value($sformatf("row %0d hilo_o.hi", i), 64'(hilo.hi), 64'(hilo_tab[i].hi), t);
			check_value($sformatf("row %0d hilo_o.lo", i), 64'(hilo.lo), 64'(hilo_tab[i].lo), t);
		end
		if (i == n_rows - 1 || row_test[i + 1] != t)
			$display("test %s finished, %0d errors", test_name[t], test_errs[t]);
	endtask

	initial begin
		reset_n = 1'b0;
		op = '0;
		build_table();
		table_ready = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
		check_value("wb_o.we after reset", 64'(wb.we), 64'(0), 0);
		check_value("hilo_o.whilo after reset", 64'(hilo.whilo), 64'(0), 0);
		for (int i = 0; i < n_rows; i++) begin
			op = op_tab[i];
			@(negedge clk);
			check_row(i);
		end
		op = '0;
		$display("tests %0d, rows %0d, checks %0d, errors %0d",
			n_tests, n_rows, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// limit scales with the table length
	initial begin
		wait (table_ready);
		#(2 * n_rows * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
		$display("watchdog expired, the run did not finish in time");
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== ex_top.f ====
+incdir+include
hw/ex_pkg.sv
hw/ex_arith_unit.sv
hw/ex_alu.sv
hw/ex_hilo_unit.sv
hw/ex_top.sv
tests/ex_top_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ex_top testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
SIM=ex_top_sim

verilator --binary --timing --assert -f ex_top.f --top-module ex_top_tb \
	-Mdir "$BUILD_DIR" -o "$SIM"
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/$SIM" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
	exit 0
fi
exit 1
